/* rtl/matrix_cfg.svh */
`ifndef MATRIX_CFG_SVH
`define MATRIX_CFG_SVH

// panel geometry
`define MATRIX_WIDTH 16
`define MATRIX_HEIGHT 8

// two bytes carry one pixel
`define BYTES_PER_PIXEL 2

// number of brightness bit-planes
`define BRIGHTNESS_LEVELS 6

// uart bit period in clk_in cycles
`define CLKS_PER_BIT 8

// bytes in one full row of pixels
`define ROW_BYTES ((`MATRIX_WIDTH) * (`BYTES_PER_PIXEL))

// covers MATRIX_HEIGHT * ROW_BYTES bytes
`define FB_ADDR_BITS 8

`endif

/* rtl/matrix_pkg.sv */
`include "matrix_cfg.svh"

package matrix_pkg;

    // one serial byte or one pixel byte
    typedef logic [7:0] byte_t;

    typedef logic [`FB_ADDR_BITS-1:0] fb_addr_t;

    typedef logic [$clog2(`MATRIX_HEIGHT)-1:0] row_t;

    // bit 0 red, bit 1 green, bit 2 blue
    typedef logic [2:0] rgb_mask_t;

    typedef logic [`BRIGHTNESS_LEVELS-1:0] brightness_t;

    typedef enum logic [1:0] {
        IDLE,
        LINE_ROW,
        LINE_DATA
    } decode_state_t;

    // one pixel-byte write into the frame buffer
    typedef struct packed {
        logic     en;
        fb_addr_t addr;
        byte_t    data;
    } fb_write_t;

endpackage

/* rtl/uart_rx.sv */
`include "matrix_cfg.svh"
`timescale 1ns/1ns

module uart_rx (
    input  logic               clk_in,
    input  logic               reset,
    input  logic               rx,
    output logic               byte_valid,
    output matrix_pkg::byte_t  rx_data
);
    localparam int CNT_BITS = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_BITS-1:0] MID_BIT = CNT_BITS'(`CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_BITS-1:0] LAST_CLK = CNT_BITS'(`CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t          state;
    logic               rx_meta;
    logic               rx_sync;
    logic               rx_last;
    logic [CNT_BITS-1:0] clk_count;
    logic [2:0]         bit_index;
    matrix_pkg::byte_t  shift_reg;

    // two-flop synchroniser plus one stage for edge detection
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= RX_IDLE;
            clk_count <= '0;
            bit_index <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_count <= '0;
                    // falling edge marks a start bit
                    if (rx_last && !rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (clk_count == MID_BIT) begin
                        clk_count <= '0;
                        bit_index <= '0;
                        // line went back high, just a glitch
                        state <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_count == LAST_CLK) begin
                        clk_count <= '0;
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_count == LAST_CLK) begin
                        clk_count <= '0;
                        // framing error drops the byte silently
                        byte_valid <= rx_sync;
                        state <= RX_IDLE;
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data path, lsb first, sampled at mid-bit
    always_ff @(posedge clk_in) begin
        if (state == RX_DATA && clk_count == LAST_CLK) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
        if (state == RX_STOP && clk_count == LAST_CLK) begin
            rx_data <= shift_reg;
        end
    end

    // a frame is 10 bits long, so strobes can never be adjacent
    assert property (@(posedge clk_in) disable iff (reset)
        byte_valid |=> !byte_valid);

endmodule

/* rtl/command_decoder.sv */
`include "matrix_cfg.svh"
`timescale 1ns/1ns

module command_decoder (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     byte_valid,
    input  matrix_pkg::byte_t        rx_data,
    output matrix_pkg::rgb_mask_t    rgb_enable,
    output matrix_pkg::brightness_t  brightness_enable,
    output matrix_pkg::fb_write_t    fb_wr
);
    localparam int COL_BITS = $clog2(`MATRIX_WIDTH);
    localparam int SEL_BITS = $clog2(`BYTES_PER_PIXEL);
    localparam logic [COL_BITS-1:0] LAST_COL = COL_BITS'(`MATRIX_WIDTH - 1);
    localparam logic [SEL_BITS-1:0] LAST_SEL = SEL_BITS'(`BYTES_PER_PIXEL - 1);

    matrix_pkg::decode_state_t  state;
    matrix_pkg::row_t           line_row;
    logic [COL_BITS-1:0]        line_col;
    logic [SEL_BITS-1:0]        line_sel;
    matrix_pkg::brightness_t    toggle_mask;
    logic                       wr_en;
    matrix_pkg::fb_addr_t       wr_addr;
    matrix_pkg::byte_t          wr_data;
    matrix_pkg::fb_addr_t       line_addr;

    // column and byte select count down, inverted they give r*32 + k
    assign line_addr = {line_row, ~line_col, ~line_sel};

    // digit d toggles plane BRIGHTNESS_LEVELS - d
    always_comb begin
        toggle_mask = '0;
        for (int i = 0; i < `BRIGHTNESS_LEVELS; i++) begin
            if (rx_data == 8'(8'h30 + `BRIGHTNESS_LEVELS - i)) begin
                toggle_mask[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= matrix_pkg::IDLE;
            rgb_enable <= '1;
            brightness_enable <= '1;
            line_row <= '0;
            line_col <= '0;
            line_sel <= '0;
            wr_en <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            if (byte_valid) begin
                case (state)
                    matrix_pkg::IDLE: begin
                        case (rx_data)
                            "R": rgb_enable[0] <= 1'b1;
                            "r": rgb_enable[0] <= 1'b0;
                            "G": rgb_enable[1] <= 1'b1;
                            "g": rgb_enable[1] <= 1'b0;
                            "B": rgb_enable[2] <= 1'b1;
                            "b": rgb_enable[2] <= 1'b0;
                            "0": brightness_enable <= '0;
                            "9": brightness_enable <= '1;
                            "L": state <= matrix_pkg::LINE_ROW;
                            // unknown bytes leave the mask at zero
                            default: brightness_enable <= brightness_enable ^ toggle_mask;
                        endcase
                    end
                    matrix_pkg::LINE_ROW: begin
                        // a repeated L still waits for the row
                        if (rx_data != "L") begin
                            line_row <= rx_data[$bits(matrix_pkg::row_t)-1:0];
                            line_col <= LAST_COL;
                            line_sel <= LAST_SEL;
                            state <= matrix_pkg::LINE_DATA;
                        end
                    end
                    matrix_pkg::LINE_DATA: begin
                        wr_en <= 1'b1;
                        if (line_col == '0 && line_sel == '0) begin
                            state <= matrix_pkg::IDLE;
                        end else if (line_sel == '0) begin
                            line_sel <= LAST_SEL;
                            line_col <= line_col - 1'b1;
                        end else begin
                            line_sel <= line_sel - 1'b1;
                        end
                    end
                    default: state <= matrix_pkg::IDLE;
                endcase
            end
        end
    end

    // payload of the write, every byte in line mode is data
    always_ff @(posedge clk_in) begin
        if (byte_valid && state == matrix_pkg::LINE_DATA) begin
            wr_addr <= line_addr;
            wr_data <= rx_data;
        end
    end

    assign fb_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

    // writes only ever follow a framed byte from the receiver
    assert property (@(posedge clk_in) disable iff (reset)
        fb_wr.en |-> $past(byte_valid));

    // a line load stays inside the row it was given
    assert property (@(posedge clk_in) disable iff (reset)
        fb_wr.en |-> fb_wr.addr[`FB_ADDR_BITS-1 -: $bits(matrix_pkg::row_t)] == line_row);

endmodule

/* rtl/frame_buffer.sv */
`include "matrix_cfg.svh"
`timescale 1ns/1ns

module frame_buffer (
    input  logic                   clk_in,
    input  matrix_pkg::fb_write_t  fb_wr,
    input  matrix_pkg::fb_addr_t   rd_addr,
    output matrix_pkg::byte_t      rd_data
);
    localparam int DEPTH = `MATRIX_HEIGHT * `ROW_BYTES;

    // row-major pixel bytes, ROW_BYTES per row
    matrix_pkg::byte_t mem [DEPTH];

    // write port from the command decoder
    always_ff @(posedge clk_in) begin
        if (fb_wr.en) begin
            mem[fb_wr.addr] <= fb_wr.data;
        end
    end

    // registered read for the scan side
    // a same-address write shows up one cycle later
    always_ff @(posedge clk_in) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* rtl/matrix_control_top.sv */
`timescale 1ns/1ns

module matrix_control_top (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     rx,
    input  matrix_pkg::fb_addr_t     rd_addr,
    output matrix_pkg::rgb_mask_t    rgb_enable,
    output matrix_pkg::brightness_t  brightness_enable,
    output matrix_pkg::byte_t        rd_data
);
    logic                   byte_valid;
    matrix_pkg::byte_t      rx_data;
    matrix_pkg::fb_write_t  fb_wr;

    // serial line to bytes
    uart_rx i_uart_rx (
        .clk_in     (clk_in),
        .reset      (reset),
        .rx         (rx),
        .byte_valid (byte_valid),
        .rx_data    (rx_data)
    );

    command_decoder i_command_decoder (
        .clk_in            (clk_in),
        .reset             (reset),
        .byte_valid        (byte_valid),
        .rx_data           (rx_data),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .fb_wr             (fb_wr)
    );

    // pixel store, read side faces the display scan
    frame_buffer i_frame_buffer (
        .clk_in  (clk_in),
        .fb_wr   (fb_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

/* bench/matrix_control_tb.sv */
`timescale 1ns/1ns
`include "matrix_cfg.svh"

module matrix_control_tb;
    // one frame plus the two idle bit times that send_byte adds
    localparam int FRAME_CYCLES = 12 * `CLKS_PER_BIT;
    localparam int MAX_FRAMES = 200;
    localparam int WATCHDOG_NS = 2 * MAX_FRAMES * FRAME_CYCLES * 4;

    logic                     clk_in = 1'b0;
    logic                     reset;
    logic                     rx;
    matrix_pkg::fb_addr_t     rd_addr;
    matrix_pkg::rgb_mask_t    rgb_enable;
    matrix_pkg::brightness_t  brightness_enable;
    matrix_pkg::byte_t        rd_data;

    // reference model of enables and frame memory
    matrix_pkg::rgb_mask_t    model_rgb;
    matrix_pkg::brightness_t  model_bright;
    matrix_pkg::byte_t        model_mem [`MATRIX_HEIGHT * `ROW_BYTES];
    logic [`MATRIX_HEIGHT-1:0] row_loaded;
    integer                   seed = 32'h81cf_1f8f;

    always #2 clk_in = ~clk_in;

    matrix_control_top i_matrix_control_top (
        .clk_in            (clk_in),
        .reset             (reset),
        .rx                (rx),
        .rd_addr           (rd_addr),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .rd_data           (rd_data)
    );

    initial begin
        #(WATCHDOG_NS);
        $display("simulation timed out before all tests finished");
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic drive_bit(input logic value);
        rx <= value;
        repeat (`CLKS_PER_BIT) @(posedge clk_in);
    endtask

    // 8N1, lsb first, then two idle bit times
    task automatic send_byte(input matrix_pkg::byte_t data, input logic bad_stop = 1'b0);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(!bad_stop);
        drive_bit(1'b1);
        drive_bit(1'b1);
    endtask

    // idle-state command, model follows the command table
    task automatic send_command(input matrix_pkg::byte_t cmd);
        int digit;
        send_byte(cmd);
        digit = int'(cmd) - int'("0");
        case (cmd)
            "R": model_rgb[0] = 1'b1;
            "r": model_rgb[0] = 1'b0;
            "G": model_rgb[1] = 1'b1;
            "g": model_rgb[1] = 1'b0;
            "B": model_rgb[2] = 1'b1;
            "b": model_rgb[2] = 1'b0;
            "0": model_bright = '0;
            "9": model_bright = '1;
            "1", "2", "3", "4", "5", "6": begin
                model_bright[`BRIGHTNESS_LEVELS - digit] = !model_bright[`BRIGHTNESS_LEVELS - digit];
            end
            default: ;
        endcase
    endtask

    // with_commands adds a second L and command-like payload bytes
    task automatic send_line(input matrix_pkg::row_t row, input logic with_commands);
        matrix_pkg::byte_t data;
        int base;
        base = int'(row) * `ROW_BYTES;
        send_byte("L");
        if (with_commands) begin
            send_byte("L");
        end
        // ascii digit, low three bits carry the row
        send_byte(8'h30 + 8'(row));
        for (int k = 0; k < `ROW_BYTES; k++) begin
            data = 8'($random(seed));
            if (with_commands && k == 3) begin
                data = "R";
            end
            if (with_commands && k == 10) begin
                data = "0";
            end
            model_mem[base + k] = data;
            send_byte(data);
        end
        row_loaded[row] = 1'b1;
    endtask

    task automatic check_rgb(input matrix_pkg::rgb_mask_t expected);
        if (rgb_enable !== expected) begin
            $display("FAILED rgb_enable expected %h actual %h", expected, rgb_enable);
            $display("TEST RESULT: FAIL");
            $fatal(1, "colour enable mismatch");
        end
    endtask

    task automatic check_brightness(input matrix_pkg::brightness_t expected);
        if (brightness_enable !== expected) begin
            $display("FAILED brightness_enable expected %h actual %h",
                     expected, brightness_enable);
            $display("TEST RESULT: FAIL");
            $fatal(1, "brightness enable mismatch");
        end
    endtask

    // registered read port, data valid one cycle after the address
    task automatic check_pixel(input matrix_pkg::fb_addr_t addr,
                               input matrix_pkg::byte_t expected);
        rd_addr <= addr;
        @(posedge clk_in);
        @(posedge clk_in);
        if (rd_data !== expected) begin
            $display("FAILED rd_data at address %h expected %h actual %h",
                     addr, expected, rd_data);
            $display("TEST RESULT: FAIL");
            $fatal(1, "frame buffer mismatch");
        end
    endtask

    task automatic check_loaded_rows();
        for (int r = 0; r < `MATRIX_HEIGHT; r++) begin
            if (row_loaded[r]) begin
                for (int k = 0; k < `ROW_BYTES; k++) begin
                    check_pixel(matrix_pkg::fb_addr_t'(r * `ROW_BYTES + k),
                                model_mem[r * `ROW_BYTES + k]);
                end
            end
        end
    endtask

    task automatic command_and_check(input matrix_pkg::byte_t cmd);
        send_command(cmd);
        check_rgb(model_rgb);
        check_brightness(model_bright);
    endtask

    task automatic test_reset_values();
        check_rgb(model_rgb);
        check_brightness(model_bright);
    endtask

    task automatic test_colour_commands();
        string seq = "rgbRGBgR";
        for (int i = 0; i < seq.len(); i++) begin
            command_and_check(seq[i]);
        end
    endtask

    // repeated digits must restore the plane
    task automatic test_brightness_commands();
        string seq = "12345622944057";
        for (int i = 0; i < seq.len(); i++) begin
            command_and_check(seq[i]);
        end
    endtask

    task automatic test_line_load();
        send_line(3'd1, 1'b0);
        send_line(3'd2, 1'b0);
        send_line(3'd6, 1'b0);
        check_loaded_rows();
        check_rgb(model_rgb);
        check_brightness(model_bright);
    endtask

    task automatic test_line_corners();
        command_and_check("r");
        command_and_check("9");
        send_line(3'd5, 1'b1);
        // R and 0 in the payload are data only
        check_rgb(model_rgb);
        check_brightness(model_bright);
        command_and_check("g");
        command_and_check("x");
        check_loaded_rows();
    endtask

    task automatic test_bad_stop_bit();
        command_and_check("R");
        send_byte("r", 1'b1);
        check_rgb(model_rgb);
        command_and_check("r");
    endtask

    initial begin
        reset = 1'b1;
        rx = 1'b1;
        rd_addr = '0;
        model_rgb = '1;
        model_bright = '1;
        row_loaded = '0;
        repeat (5) @(posedge clk_in);
        reset <= 1'b0;
        @(posedge clk_in);
        test_reset_values();
        test_colour_commands();
        test_brightness_commands();
        test_line_load();
        test_line_corners();
        test_bad_stop_bit();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* matrix_control_top.f */
+incdir+rtl
rtl/matrix_pkg.sv
rtl/uart_rx.sv
rtl/command_decoder.sv
rtl/frame_buffer.sv
rtl/matrix_control_top.sv
bench/matrix_control_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module matrix_control_tb -f matrix_control_top.f -o matrix_control_sim

output=$(./obj_dir/matrix_control_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q "TEST RESULT: PASS"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
